// ==== src/uart_pkg.sv ====
package uart_pkg;

    ////////////////////////////////////////////////////////////
    // baud timing
    ////////////////////////////////////////////////////////////

    // rx_clk cycles per oversample tick.
    localparam int sample_div = 4;

    // oversample ticks per serial bit, so one bit is 64 cycles.
    localparam int oversample = 16;

    localparam int data_bits = 8;

    ////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////

    typedef logic [7:0] uart_byte_t;
    typedef logic [3:0] sample_cnt_t;
    typedef logic [2:0] bit_cnt_t;

    // one received 8N1 frame as handed to the echo block.
    typedef struct packed {
        uart_byte_t data;
        logic       framing_error;
    } rx_frame_t;

    ////////////////////////////////////////////////////////////
    // state machines
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop,
        rx_hold
    } rx_state_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

endpackage

// ==== src/baud_tick_gen.sv ====
module baud_tick_gen import uart_pkg::*; (
    input  logic rx_clk,
    input  logic reset,
    output logic sample_tick,
    output logic bit_tick
);

    typedef logic [$clog2(sample_div)-1:0] div_cnt_t;

    div_cnt_t    div_cnt;
    sample_cnt_t sample_cnt;
    logic        div_wrap;
    logic        sample_wrap;

    assign div_wrap    = (div_cnt == div_cnt_t'(sample_div - 1));
    assign sample_wrap = (sample_cnt == sample_cnt_t'(oversample - 1));

    // prescaler for the oversample tick.
    always_ff @(posedge rx_clk) begin
        if (reset) begin
            div_cnt     <= '0;
            sample_tick <= 1'b0;
        end else begin
            sample_tick <= div_wrap;
            div_cnt     <= div_wrap ? '0 : div_cnt + 1'b1;
        end
    end

    // bit tick lands on every sixteenth sample tick.
    always_ff @(posedge rx_clk) begin
        if (reset) begin
            sample_cnt <= '0;
            bit_tick   <= 1'b0;
        end else begin
            bit_tick <= 1'b0;
            if (div_wrap) begin
                sample_cnt <= sample_cnt + 1'b1;
                bit_tick   <= sample_wrap;
            end
        end
    end

endmodule

// ==== src/uart_rx.sv ====
module uart_rx import uart_pkg::*; (
    input  logic      rx_clk,
    input  logic      reset,
    input  logic      sample_tick,
    input  logic      rx_in,
    output logic      rx_req,
    output rx_frame_t rx_frame,
    input  logic      rx_ack
);

    logic        rx_meta;
    logic        rx_sync;
    logic        rx_prev;
    logic        start_edge;
    logic        mid_start;
    logic        bit_end;
    logic        hs_free;
    logic        frame_done;
    rx_state_t   state;
    sample_cnt_t sample_cnt;
    bit_cnt_t    bit_cnt;
    uart_byte_t  shift_reg;

    ////////////////////////////////////////////////////////////
    // input synchronizer
    ////////////////////////////////////////////////////////////

    // the line idles high.
    always_ff @(posedge rx_clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_in;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = rx_prev & ~rx_sync;
    assign mid_start  = sample_tick && (sample_cnt == sample_cnt_t'(oversample / 2 - 1));
    assign bit_end    = sample_tick && (sample_cnt == sample_cnt_t'(oversample - 1));
    assign hs_free    = ~rx_req & ~rx_ack;
    assign frame_done = (state == rx_stop) && bit_end;

    ////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge rx_clk) begin
        if (reset) begin
            state      <= rx_idle;
            sample_cnt <= '0;
            bit_cnt    <= '0;
        end else begin
            if (sample_tick) begin
                sample_cnt <= sample_cnt + 1'b1;
            end
            case (state)
                rx_idle: begin
                    if (start_edge) begin
                        state      <= rx_start;
                        sample_cnt <= '0;
                    end
                end
                rx_start: begin
                    // a start bit that is high again at mid-bit was a glitch.
                    if (mid_start) begin
                        state      <= rx_sync ? rx_idle : rx_data;
                        sample_cnt <= '0;
                        bit_cnt    <= '0;
                    end
                end
                rx_data: begin
                    if (bit_end) begin
                        if (bit_cnt == bit_cnt_t'(data_bits - 1)) begin
                            state <= rx_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                rx_stop: begin
                    // frame is dropped when the last one is still in flight.
                    if (bit_end) begin
                        state <= hs_free ? rx_hold : rx_idle;
                    end
                end
                rx_hold: begin
                    if (start_edge) begin
                        state      <= rx_start;
                        sample_cnt <= '0;
                    end else if (hs_free) begin
                        state <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // data bits arrive lsb first.
    always_ff @(posedge rx_clk) begin
        if ((state == rx_data) && bit_end) begin
            shift_reg <= {rx_sync, shift_reg[data_bits-1:1]};
        end
        if (frame_done && hs_free) begin
            rx_frame.data          <= shift_reg;
            rx_frame.framing_error <= ~rx_sync;
        end
    end

    always_ff @(posedge rx_clk) begin
        if (reset) begin
            rx_req <= 1'b0;
        end else if (frame_done && hs_free) begin
            rx_req <= 1'b1;
        end else if (rx_ack) begin
            rx_req <= 1'b0;
        end
    end

endmodule

// ==== src/uart_tx.sv ====
module uart_tx import uart_pkg::*; (
    input  logic       rx_clk,
    input  logic       reset,
    input  logic       bit_tick,
    input  logic       tx_req,
    input  uart_byte_t tx_byte,
    output logic       tx_ack,
    output logic       tx_out
);

    tx_state_t  state;
    bit_cnt_t   bit_cnt;
    uart_byte_t shift_reg;
    logic       accept;

    // a new byte is taken only between frames.
    assign accept = (state == tx_idle) && tx_req && !tx_ack;

    ////////////////////////////////////////////////////////////
    // request handshake
    ////////////////////////////////////////////////////////////

    always_ff @(posedge rx_clk) begin
        if (reset) begin
            tx_ack <= 1'b0;
        end else if (accept) begin
            tx_ack <= 1'b1;
        end else if (tx_ack && !tx_req) begin
            tx_ack <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // serializer
    ////////////////////////////////////////////////////////////

    // each state names the bit driven at the next bit tick.
    always_ff @(posedge rx_clk) begin
        if (reset) begin
            state   <= tx_idle;
            bit_cnt <= '0;
            tx_out  <= 1'b1;
        end else begin
            case (state)
                tx_idle: begin
                    if (accept) begin
                        state <= tx_start;
                    end
                end
                tx_start: begin
                    if (bit_tick) begin
                        tx_out  <= 1'b0;
                        bit_cnt <= '0;
                        state   <= tx_data;
                    end
                end
                tx_data: begin
                    if (bit_tick) begin
                        tx_out <= shift_reg[0];
                        if (bit_cnt == bit_cnt_t'(data_bits - 1)) begin
                            state <= tx_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                tx_stop: begin
                    // stop bit runs on while idle, next start follows at the tick.
                    if (bit_tick) begin
                        tx_out <= 1'b1;
                        state  <= tx_idle;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    always_ff @(posedge rx_clk) begin
        if (accept) begin
            shift_reg <= tx_byte;
        end else if ((state == tx_data) && bit_tick) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

// ==== src/case_echo.sv ====
module case_echo import uart_pkg::*; (
    input  logic       rx_clk,
    input  logic       reset,
    input  logic       rx_req,
    input  rx_frame_t  rx_frame,
    output logic       rx_ack,
    output uart_byte_t leds,
    output logic       tx_req,
    output uart_byte_t tx_byte,
    input  logic       tx_ack
);

    uart_byte_t last_sent;
    uart_byte_t flipped;
    logic       tx_busy;
    logic       accept;
    logic       good_frame;
    logic       echo_due;

    ////////////////////////////////////////////////////////////
    // frame intake
    ////////////////////////////////////////////////////////////

    // hold off the next frame while a transfer to the transmitter is open.
    assign tx_busy    = tx_req | tx_ack;
    assign accept     = rx_req & ~rx_ack & ~tx_busy;
    assign good_frame = ~rx_frame.framing_error;

    // bit 5 swaps the case of an ascii letter.
    assign flipped  = {rx_frame.data[7:6], ~rx_frame.data[5], rx_frame.data[4:0]};
    assign echo_due = good_frame && (flipped != last_sent);

    always_ff @(posedge rx_clk) begin
        if (reset) begin
            rx_ack <= 1'b0;
        end else if (accept) begin
            rx_ack <= 1'b1;
        end else if (rx_ack && !rx_req) begin
            rx_ack <= 1'b0;
        end
    end

    always_ff @(posedge rx_clk) begin
        if (reset) begin
            leds <= '0;
        end else if (accept && good_frame) begin
            leds <= rx_frame.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // echo request
    ////////////////////////////////////////////////////////////

    // repeats of the last sent byte are not echoed.
    always_ff @(posedge rx_clk) begin
        if (reset) begin
            last_sent <= '0;
        end else if (accept && echo_due) begin
            last_sent <= flipped;
        end
    end

    always_ff @(posedge rx_clk) begin
        if (reset) begin
            tx_req <= 1'b0;
        end else if (accept && echo_due) begin
            tx_req <= 1'b1;
        end else if (tx_ack) begin
            tx_req <= 1'b0;
        end
    end

    // the byte on offer is always the last one sent.
    assign tx_byte = last_sent;

endmodule

// ==== src/uart_echo_top.sv ====
module uart_echo_top import uart_pkg::*; (
    input  logic       rx_clk,
    input  logic       reset,
    input  logic       rx_in,
    output logic       tx_out,
    output uart_byte_t leds
);

    logic       sample_tick;
    logic       bit_tick;
    logic       rx_req;
    logic       rx_ack;
    rx_frame_t  rx_frame;
    logic       tx_req;
    logic       tx_ack;
    uart_byte_t tx_byte;

    // both baud ticks come from one divider.
    baud_tick_gen i_baud_tick_gen (
        .rx_clk      (rx_clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .bit_tick    (bit_tick)
    );

    uart_rx i_uart_rx (
        .rx_clk      (rx_clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .rx_in       (rx_in),
        .rx_req      (rx_req),
        .rx_frame    (rx_frame),
        .rx_ack      (rx_ack)
    );

    case_echo i_case_echo (
        .rx_clk   (rx_clk),
        .reset    (reset),
        .rx_req   (rx_req),
        .rx_frame (rx_frame),
        .rx_ack   (rx_ack),
        .leds     (leds),
        .tx_req   (tx_req),
        .tx_byte  (tx_byte),
        .tx_ack   (tx_ack)
    );

    uart_tx i_uart_tx (
        .rx_clk   (rx_clk),
        .reset    (reset),
        .bit_tick (bit_tick),
        .tx_req   (tx_req),
        .tx_byte  (tx_byte),
        .tx_ack   (tx_ack),
        .tx_out   (tx_out)
    );

endmodule

// ==== dv/uart_echo_checker.sv ====
module uart_echo_checker import uart_pkg::*; (
    input logic       rx_clk,
    input logic       reset,
    input logic       rx_req,
    input logic       rx_ack,
    input rx_frame_t  rx_frame,
    input logic       tx_req,
    input logic       tx_ack,
    input uart_byte_t tx_byte,
    input tx_state_t  tx_state,
    input logic       tx_out
);

    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;

    // the echo byte is held on offer until the transmitter takes it.
    tx_req_held: assert property (@(posedge rx_clk) disable iff (reset)
        tx_req && !tx_ack |=> tx_req && $stable(tx_byte))
    else begin
        $error("tx_req dropped or tx_byte changed before tx_ack");
        assert_fails++;
    end

    rx_req_held: assert property (@(posedge rx_clk) disable iff (reset)
        rx_req && !rx_ack |=> rx_req && $stable(rx_frame))
    else begin
        $error("rx_req dropped or rx_frame changed before rx_ack");
        assert_fails++;
    end

    // line rests at the stop level between frames.
    tx_idle_high: assert property (@(posedge rx_clk) disable iff (reset)
        tx_state == tx_idle |-> tx_out)
    else begin
        $error("tx_out low while the transmitter is idle");
        assert_fails++;
    end

endmodule

bind uart_echo_top uart_echo_checker i_uart_echo_checker (
    .rx_clk   (rx_clk),
    .reset    (reset),
    .rx_req   (rx_req),
    .rx_ack   (rx_ack),
    .rx_frame (rx_frame),
    .tx_req   (tx_req),
    .tx_ack   (tx_ack),
    .tx_byte  (tx_byte),
    .tx_state (i_uart_tx.state),
    .tx_out   (tx_out)
);

// ==== dv/uart_echo_monitor.sv ====
module uart_echo_monitor import uart_pkg::*; (
    input  logic       rx_clk,
    input  logic       reset,
    input  logic       tx_out,
    input  uart_byte_t leds,
    input  logic       frame_post,
    input  rx_frame_t  frame_info,
    output logic       idle,
    output int         mismatch_count,
    output int         fault_count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int bit_cycles = sample_div * oversample;

    typedef struct packed {
        logic [31:0] due;
        uart_byte_t  echo;
        uart_byte_t  leds;
    } echo_exp_t;

    typedef struct packed {
        logic [31:0] due;
        uart_byte_t  leds;
    } leds_exp_t;

    echo_exp_t   echo_q[$];
    leds_exp_t   leds_q[$];
    echo_exp_t   current;
    logic        have_current;
    uart_byte_t  model_last;
    uart_byte_t  model_leds;
    uart_byte_t  shift;
    logic        seen_frame;
    logic        line_prev;
    int          bit_pos;
    int          phase;
    logic [31:0] cycle;

    // bit 5 is the ascii case bit.
    function automatic uart_byte_t echo_of(input uart_byte_t data);
        return data ^ 8'h20;
    endfunction

    always @(posedge rx_clk) begin
        if (reset) begin
            echo_q.delete();
            leds_q.delete();
            have_current = 1'b0;
            current = '0;
            model_last = '0;
            model_leds = '0;
            shift = '0;
            seen_frame = 1'b0;
            line_prev = 1'b1;
            bit_pos = -1;
            phase = 0;
            cycle = '0;
            mismatch_count = 0;
            fault_count = 0;
        end else begin
            cycle = cycle + 1;

            ////////////////////////////////////////////////////////////
            // expected side
            ////////////////////////////////////////////////////////////

            if (frame_post) begin
                seen_frame = 1'b1;
                if (frame_info.framing_error) begin
                    leds_q.push_back('{due: cycle + 2 * bit_cycles, leds: model_leds});
                end else if (echo_of(frame_info.data) != model_last) begin
                    model_leds = frame_info.data;
                    model_last = echo_of(frame_info.data);
                    echo_q.push_back('{due: cycle + 4 * bit_cycles, echo: model_last,
                                       leds: model_leds});
                end else begin
                    model_leds = frame_info.data;
                    leds_q.push_back('{due: cycle + 2 * bit_cycles, leds: model_leds});
                end
            end

            if (!seen_frame && leds !== 8'h00) begin
                $display("Mismatch at %0t: leds %h before the first frame, expected 00",
                         $time, leds);
                mismatch_count++;
            end
            if (!seen_frame && tx_out !== 1'b1) begin
                $display("Error at %0t: tx_out left idle before the first frame", $time);
                fault_count++;
            end

            if (leds_q.size() > 0 && leds_q[0].due == cycle) begin
                if (leds !== leds_q[0].leds) begin
                    $display("Mismatch at %0t: leds %h, expected %h",
                             $time, leds, leds_q[0].leds);
                    mismatch_count++;
                end
                void'(leds_q.pop_front());
            end

            if (bit_pos < 0 && echo_q.size() > 0 && cycle > echo_q[0].due) begin
                $display("Error at %0t: echo of %h never appeared on tx_out",
                         $time, echo_q[0].echo);
                fault_count++;
                void'(echo_q.pop_front());
            end

            ////////////////////////////////////////////////////////////
            // tx_out decoder
            ////////////////////////////////////////////////////////////

            if (bit_pos < 0) begin
                if (line_prev && !tx_out) begin
                    bit_pos = 0;
                    phase = 0;
                end
            end else begin
                phase = phase + 1;
                if (phase == bit_cycles / 2 + bit_pos * bit_cycles) begin
                    if (bit_pos == 0) begin
                        if (tx_out) begin
                            $display("Error at %0t: start bit on tx_out did not stay low",
                                     $time);
                            fault_count++;
                            bit_pos = -1;
                        end else if (echo_q.size() == 0) begin
                            $display("Error at %0t: tx_out sent an echo no frame called for",
                                     $time);
                            fault_count++;
                            have_current = 1'b0;
                            bit_pos = 1;
                        end else begin
                            current = echo_q.pop_front();
                            have_current = 1'b1;
                            if (leds !== current.leds) begin
                                $display("Mismatch at %0t: leds %h, expected %h",
                                         $time, leds, current.leds);
                                mismatch_count++;
                            end
                            bit_pos = 1;
                        end
                    end else if (bit_pos <= data_bits) begin
                        shift = {tx_out, shift[7:1]};
                        bit_pos = bit_pos + 1;
                    end else begin
                        if (!tx_out) begin
                            $display("Error at %0t: stop bit on tx_out read low", $time);
                            fault_count++;
                        end
                        if (have_current && shift !== current.echo) begin
                            $display("Mismatch at %0t: echo %h, expected %h",
                                     $time, shift, current.echo);
                            mismatch_count++;
                        end
                        have_current = 1'b0;
                        bit_pos = -1;
                    end
                end
            end
            line_prev = tx_out;
        end
        idle = (echo_q.size() == 0) && (leds_q.size() == 0) && (bit_pos < 0);
    end

endmodule

// ==== dv/uart_echo_tb.sv ====
module uart_echo_tb import uart_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int bit_cycles    = sample_div * oversample;
    localparam int intro_frames  = 8;
    localparam int repeat_frames = 5;
    localparam int error_frames  = 3;
    localparam int burst_frames  = 20;
    localparam int random_frames = 200;
    localparam int total_frames  = intro_frames + repeat_frames + error_frames
                                   + burst_frames + random_frames;
    localparam int cycle_limit   = total_frames * bit_cycles * 10 * 2 + 2000;

    logic       rx_clk = 1'b0;
    logic       reset;
    logic       rx_in;
    logic       tx_out;
    uart_byte_t leds;
    logic       frame_post;
    rx_frame_t  frame_info;
    logic       monitor_idle;
    int         mismatch_count;
    int         fault_count;
    int         seed = 72;
    int         cycle_count = 0;

    uart_echo_top i_uart_echo_top (
        .rx_clk (rx_clk),
        .reset  (reset),
        .rx_in  (rx_in),
        .tx_out (tx_out),
        .leds   (leds)
    );

    uart_echo_monitor i_uart_echo_monitor (
        .rx_clk         (rx_clk),
        .reset          (reset),
        .tx_out         (tx_out),
        .leds           (leds),
        .frame_post     (frame_post),
        .frame_info     (frame_info),
        .idle           (monitor_idle),
        .mismatch_count (mismatch_count),
        .fault_count    (fault_count)
    );

    always #5 rx_clk = ~rx_clk;

    always @(posedge rx_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Error: run did not finish within %0d cycles (%0d mismatches, %0d other)",
                     cycle_limit, mismatch_count, fault_count);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic hold_bits(input int n);
        repeat (n * bit_cycles) @(negedge rx_clk);
    endtask

    // one 8N1 frame, lsb first, then gap_bits of idle line.
    task automatic send_frame(input uart_byte_t data, input logic bad_stop, input int gap_bits);
        int i;
        int gap;
        gap = (bad_stop && gap_bits < 1) ? 1 : gap_bits;
        rx_in = 1'b0;
        hold_bits(1);
        for (i = 0; i < data_bits; i++) begin
            rx_in = data[i];
            hold_bits(1);
        end
        rx_in = ~bad_stop;
        frame_info = '{data: data, framing_error: bad_stop};
        frame_post = 1'b1;
        @(negedge rx_clk);
        frame_post = 1'b0;
        repeat (bit_cycles - 1) @(negedge rx_clk);
        rx_in = 1'b1;
        hold_bits(gap);
    endtask

    function automatic uart_byte_t random_byte();
        return uart_byte_t'($random(seed));
    endfunction

    initial begin
        int         i;
        int         total;
        uart_byte_t b;
        uart_byte_t prev;
        logic       bad;
        reset = 1'b1;
        rx_in = 1'b1;
        frame_post = 1'b0;
        frame_info = '0;
        prev = '0;
        repeat (3) @(posedge rx_clk);
        @(negedge rx_clk);
        reset = 1'b0;

        // quiet line first, the monitor watches leds and tx_out.
        hold_bits(4);

        for (i = 0; i < intro_frames; i++) begin
            send_frame(random_byte(), 1'b0, 1 + {$random(seed)} % 3);
        end

        // second copy of each byte must not be echoed.
        send_frame(8'h61, 1'b0, 1);
        send_frame(8'h61, 1'b0, 1);
        send_frame(8'h41, 1'b0, 1);
        send_frame(8'h41, 1'b0, 1);
        send_frame(8'h7a, 1'b0, 1);

        send_frame(8'h4b, 1'b0, 1);
        send_frame(8'h7a, 1'b1, 2);
        send_frame(8'h71, 1'b0, 1);

        ////////////////////////////////////////////////////////////
        // back to back burst
        ////////////////////////////////////////////////////////////

        for (i = 0; i < burst_frames; i++) begin
            b = (i == 10) ? prev : random_byte();
            send_frame(b, 1'b0, 0);
            prev = b;
        end

        ////////////////////////////////////////////////////////////
        // long random run
        ////////////////////////////////////////////////////////////

        for (i = 0; i < random_frames; i++) begin
            bad = ({$random(seed)} % 16) == 0;
            b = (({$random(seed)} % 8) == 0) ? prev : random_byte();
            send_frame(b, bad, {$random(seed)} % 4);
            prev = b;
        end

        wait (monitor_idle);
        hold_bits(3);

        total = mismatch_count + fault_count
                + i_uart_echo_top.i_uart_echo_checker.assert_fails;
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatch_count, fault_count,
                 i_uart_echo_top.i_uart_echo_checker.assert_fails);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/uart_pkg.sv
src/baud_tick_gen.sv
src/uart_rx.sv
src/uart_tx.sv
src/case_echo.sv
src/uart_echo_top.sv
dv/uart_echo_checker.sv
dv/uart_echo_monitor.sv
dv/uart_echo_tb.sv
